//--- sources.f
common/eeprom_pkg.sv
eeprom/i2c_shifter.sv
eeprom/eeprom_ctrl.sv
verilog/eeprom_top.sv
test/eeprom_chk.sv
test/eeprom_model.sv
test/tb_eeprom.sv

//--- Bender.yml
package:
  name: eeprom_access

sources:
  - files:
      - common/eeprom_pkg.sv
      - eeprom/i2c_shifter.sv
      - eeprom/eeprom_ctrl.sv
      - verilog/eeprom_top.sv
  - target: test
    files:
      - test/eeprom_chk.sv
      - test/eeprom_model.sv
      - test/tb_eeprom.sv

//--- test/tb_eeprom.sv
module tb_eeprom;

    localparam int ACK_TIMEOUT = 100 * 4 * eeprom_pkg::QUARTER_CYCLES;

    logic                     CLK;
    logic                     RESET;
    logic                     WR;
    logic                     RD;
    eeprom_pkg::eeprom_addr_t addr;
    eeprom_pkg::eeprom_byte_t wr_data;
    eeprom_pkg::eeprom_byte_t rd_data;
    logic                     ACK;
    logic                     SCL;
    wire                      SDA;

    eeprom_pkg::eeprom_byte_t shadow_mem [0:2047];
    logic                     shadow_valid [0:2047];
    logic [31:0]              rng_state;
    int                       req_count;
    int                       ack_count;
    logic                     read_pending;
    eeprom_pkg::eeprom_byte_t read_expect;

    pullup (SDA);

    eeprom_top eeprom_top_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .WR      (WR),
        .RD      (RD),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ACK     (ACK),
        .SCL     (SCL),
        .SDA     (SDA)
    );

    eeprom_model eeprom_model_inst (
        .scl (SCL),
        .sda (SDA)
    );

    always #4 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // last written value, else the power-up fill
    function automatic eeprom_pkg::eeprom_byte_t expected_byte(input eeprom_pkg::eeprom_addr_t a);
        if (shadow_valid[a])
            return shadow_mem[a];
        return a[7:0] ^ 8'h5A ^ {a[10:8], 5'b0};
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic send_request(input logic do_wr, input logic do_rd,
                                input eeprom_pkg::eeprom_addr_t a,
                                input eeprom_pkg::eeprom_byte_t d);
        @(posedge CLK);
        #1;
        WR      = do_wr;
        RD      = do_rd;
        addr    = a;
        wr_data = d;
        @(posedge CLK);
        #1;
        WR = 1'b0;   // addr and data stay until ACK
        RD = 1'b0;
    endtask

    task automatic wait_ack();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < ACK_TIMEOUT && !seen; i++)
        begin
            @(negedge CLK);
            seen = ACK;
        end
        #1;   // step off the sampling edge
        if (!seen)
            abort_run("no ACK within the timeout");
    endtask

    task automatic start_write(input eeprom_pkg::eeprom_addr_t a,
                               input eeprom_pkg::eeprom_byte_t d, input logic with_rd);
        shadow_mem[a]   = d;
        shadow_valid[a] = 1'b1;
        read_pending    = 1'b0;
        req_count++;
        send_request(1'b1, with_rd, a, d);
    endtask

    task automatic start_read(input eeprom_pkg::eeprom_addr_t a);
        read_expect  = expected_byte(a);
        read_pending = 1'b1;
        req_count++;
        send_request(1'b0, 1'b1, a, '0);
    endtask

    task automatic do_write(input eeprom_pkg::eeprom_addr_t a, input eeprom_pkg::eeprom_byte_t d);
        start_write(a, d, 1'b0);
        wait_ack();
    endtask

    task automatic do_read(input eeprom_pkg::eeprom_addr_t a);
        start_read(a);
        wait_ack();
    endtask

    always @(negedge CLK)
    begin
        if (!RESET && ACK)
        begin
            ack_count = ack_count + 1;
            if (read_pending)
                check_value("rd_data", rd_data, read_expect);
            read_pending = 1'b0;
        end
        if (eeprom_top_inst.eeprom_ctrl_inst.eeprom_chk_inst.fail_count != 0)
            abort_run("a protocol assertion on the sequencer failed");
    end

    initial
    begin
        eeprom_pkg::eeprom_addr_t a;
        logic [31:0]              r;
        CLK          = 1'b0;
        RESET        = 1'b1;
        WR           = 1'b0;
        RD           = 1'b0;
        addr         = '0;
        wr_data      = '0;
        rng_state    = 32'haad4997d;
        req_count    = 0;
        ack_count    = 0;
        read_pending = 1'b0;
        for (int i = 0; i < 2048; i++)
            shadow_valid[i] = 1'b0;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;

        repeat (6)
        begin
            @(negedge CLK);
            check_value("ACK", ACK, 0);
            check_value("SCL", SCL, 1);
            check_value("SDA", SDA, 1);
        end

        do_write(11'h023, 8'hC3);
        do_read(11'h023);
        do_read(11'h045);   // never written

        // same low byte in every block
        for (int b = 0; b < 8; b++)
            do_write({b[2:0], 8'h3C}, eeprom_pkg::eeprom_byte_t'(8'h11 * (b + 1)));
        for (int b = 0; b < 8; b++)
            do_read({b[2:0], 8'h3C});

        a = '0;
        for (int n = 0; n < 40; n++)
        begin
            rng_state = xorshift32(rng_state);
            r         = rng_state;
            if (r[0])
            begin
                a = r[11:1];
                do_write(a, r[19:12]);
            end
            else if (r[20])
                do_read(a);   // revisit last written address
            else
                do_read(r[31:21]);
        end

        // WR strobe in the middle of a read must be dropped
        start_read(11'h5A7);
        repeat (50) @(posedge CLK);
        #1;
        WR      = 1'b1;
        addr    = 11'h1B2;
        wr_data = 8'hE4;
        @(posedge CLK);
        #1;
        WR   = 1'b0;
        addr = 11'h5A7;
        wait_ack();
        repeat (200) @(posedge CLK);
        check_value("ack_count", ack_count, req_count);
        do_read(11'h1B2);

        start_write(11'h6E1, 8'h9D, 1'b1);   // WR and RD together
        wait_ack();
        do_read(11'h6E1);

        repeat (20) @(posedge CLK);
        if (ack_count == req_count)
        begin
            $display("No errors");
            $finish;
        end
        else
            abort_run("number of ACK pulses differs from number of requests");
    end

endmodule

//--- test/eeprom_model.sv
module eeprom_model (
    input  logic scl,
    inout  wire  sda
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_t;

    eeprom_pkg::eeprom_byte_t mem [0:2047];
    model_state_t             state;
    model_state_t             after_ack;
    eeprom_pkg::eeprom_byte_t shreg;
    eeprom_pkg::eeprom_addr_t ptr;
    int                       bit_idx;
    logic                     in_ack;
    logic                     drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    // power-up fill: low byte xor 5a, block number folded into bits 7:5
    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ 8'h5A ^ {a[10:8], 5'b0};
        state     = M_IDLE;
        after_ack = M_IDLE;
        bit_idx   = 0;
        in_ack    = 1'b0;
        drive_low = 1'b0;
        ptr       = '0;
    end

    always @(negedge sda)
    begin
        if (scl === 1'b1)   // start or repeated start
        begin
            state   = M_CTRL;
            bit_idx = 0;
            in_ack  = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            state = M_IDLE;   // stop
    end

    task automatic take_byte();
        after_ack = M_IDLE;
        case (state)
            M_CTRL:
            begin
                if (shreg[7:4] != eeprom_pkg::CTRL_CODE)
                begin
                    state = M_IDLE;   // not addressed, no ack
                    return;
                end
                ptr[10:8] = shreg[3:1];
                after_ack = shreg[0] ? M_RDATA : M_ADDR;
            end
            M_ADDR:
            begin
                ptr[7:0]  = shreg;
                after_ack = M_WDATA;
            end
            default:
                mem[ptr] = shreg;
        endcase
        in_ack    = 1'b1;
        drive_low = 1'b1;
    endtask

    always @(posedge scl)
    begin
        case (state)
            M_CTRL, M_ADDR, M_WDATA:
                if (!in_ack && bit_idx < 8)
                begin
                    shreg   = {shreg[6:0], sda};
                    bit_idx = bit_idx + 1;
                end
            M_RDATA:
                if (bit_idx < 8)
                    bit_idx = bit_idx + 1;
                else
                    state = M_IDLE;   // master ack slot, single byte only
            default:
                ;
        endcase
    end

    always @(negedge scl)
    begin
        case (state)
            M_CTRL, M_ADDR, M_WDATA:
                if (in_ack)
                begin
                    in_ack    = 1'b0;
                    drive_low = 1'b0;
                    bit_idx   = 0;
                    state     = after_ack;
                    if (state == M_RDATA)
                    begin
                        shreg     = mem[ptr];
                        drive_low = !shreg[7];
                    end
                end
                else if (bit_idx == 8)
                    take_byte();
            M_RDATA:
                drive_low = (bit_idx < 8) ? !shreg[7 - bit_idx] : 1'b0;
            default:
                drive_low = 1'b0;
        endcase
    end

endmodule

//--- test/eeprom_chk.sv
module eeprom_chk (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    ACK,
    input  logic                    cmd_valid,
    input  eeprom_pkg::ctrl_state_t state
);

    int fail_count = 0;

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ACK |=> !ACK)
        else
        begin
            $error("ACK high for two consecutive cycles");
            fail_count++;
        end

    // no engine command while idle or acknowledging
    cmd_in_transaction: assert property (@(posedge CLK) disable iff (RESET)
        (state == eeprom_pkg::CS_IDLE || state == eeprom_pkg::CS_ACK) |-> !cmd_valid)
        else
        begin
            $error("cmd_valid high outside a transaction");
            fail_count++;
        end

endmodule

bind eeprom_ctrl eeprom_chk eeprom_chk_inst (
    .CLK       (CLK),
    .RESET     (RESET),
    .ACK       (ACK),
    .cmd_valid (cmd_valid),
    .state     (state)
);

//--- verilog/eeprom_top.sv
module eeprom_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      WR,
    input  logic                      RD,
    input  eeprom_pkg::eeprom_addr_t  addr,
    input  eeprom_pkg::eeprom_byte_t  wr_data,
    output eeprom_pkg::eeprom_byte_t  rd_data,
    output logic                      ACK,
    output logic                      SCL,
    inout  wire                       SDA
);

    logic                     cmd_valid;
    eeprom_pkg::i2c_cmd_t     cmd;
    eeprom_pkg::eeprom_byte_t tx_byte;
    logic                     last_read;
    logic                     cmd_done;
    eeprom_pkg::eeprom_byte_t rx_byte;
    logic                     sda_low;
    logic                     sda_in;

    assign SDA    = sda_low ? 1'b0 : 1'bz;   // open drain, pull-up on board
    assign sda_in = SDA;

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .WR        (WR),
        .RD        (RD),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ACK       (ACK),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .last_read (last_read),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte)
    );

    i2c_shifter i2c_shifter_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .last_read (last_read),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .scl       (SCL),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

//--- eeprom/eeprom_ctrl.sv
module eeprom_ctrl (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      WR,
    input  logic                      RD,
    input  eeprom_pkg::eeprom_addr_t  addr,
    input  eeprom_pkg::eeprom_byte_t  wr_data,
    output eeprom_pkg::eeprom_byte_t  rd_data,
    output logic                      ACK,
    output logic                      cmd_valid,
    output eeprom_pkg::i2c_cmd_t      cmd,
    output eeprom_pkg::eeprom_byte_t  tx_byte,
    output logic                      last_read,
    input  logic                      cmd_done,
    input  eeprom_pkg::eeprom_byte_t  rx_byte
);

    eeprom_pkg::ctrl_state_t  state;
    eeprom_pkg::ctrl_state_t  state_next;
    eeprom_pkg::i2c_cmd_t     cmd_next;
    eeprom_pkg::eeprom_byte_t tx_next;
    eeprom_pkg::eeprom_byte_t ctrl_wr_byte;
    eeprom_pkg::eeprom_byte_t ctrl_rd_byte;
    logic                     last_next;
    logic                     issue;
    logic                     start_req;
    logic                     is_read;     // current transaction is a read

    assign ctrl_wr_byte = {eeprom_pkg::CTRL_CODE, addr[10:8], 1'b0};
    assign ctrl_rd_byte = {eeprom_pkg::CTRL_CODE, addr[10:8], 1'b1};

    // requests only count in idle, write wins a tie
    assign start_req = (state == eeprom_pkg::CS_IDLE) && (WR || RD);

    always_comb
    begin
        state_next = state;
        issue      = 1'b0;
        cmd_next   = eeprom_pkg::CMD_START;
        tx_next    = ctrl_wr_byte;
        last_next  = 1'b0;
        case (state)
            eeprom_pkg::CS_IDLE:
                if (start_req)
                begin
                    state_next = eeprom_pkg::CS_WR_START;
                    issue      = 1'b1;
                end
            eeprom_pkg::CS_WR_START:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_CTRL_WR;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_WRITE;
                end
            eeprom_pkg::CS_CTRL_WR:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_ADDR_WR;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_WRITE;
                    tx_next    = addr[7:0];
                end
            eeprom_pkg::CS_ADDR_WR:
                if (cmd_done)
                begin
                    issue = 1'b1;
                    if (is_read)
                    begin
                        state_next = eeprom_pkg::CS_RD_START;   // repeated start
                    end
                    else
                    begin
                        state_next = eeprom_pkg::CS_DATA_WR;
                        cmd_next   = eeprom_pkg::CMD_WRITE;
                        tx_next    = wr_data;
                    end
                end
            eeprom_pkg::CS_DATA_WR:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_STOP;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_STOP;
                end
            eeprom_pkg::CS_RD_START:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_CTRL_RD;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_WRITE;
                    tx_next    = ctrl_rd_byte;
                end
            eeprom_pkg::CS_CTRL_RD:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_DATA_RD;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_READ;
                    last_next  = 1'b1;   // single byte, nack it
                end
            eeprom_pkg::CS_DATA_RD:
                if (cmd_done)
                begin
                    state_next = eeprom_pkg::CS_STOP;
                    issue      = 1'b1;
                    cmd_next   = eeprom_pkg::CMD_STOP;
                end
            eeprom_pkg::CS_STOP:
                if (cmd_done)
                    state_next = eeprom_pkg::CS_ACK;
            eeprom_pkg::CS_ACK:
                state_next = eeprom_pkg::CS_IDLE;
            default:
                state_next = eeprom_pkg::CS_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::CS_IDLE;
            cmd_valid <= 1'b0;
            ACK       <= 1'b0;
            is_read   <= 1'b0;
            rd_data   <= '0;
        end
        else
        begin
            state     <= state_next;
            cmd_valid <= issue;
            ACK       <= (state == eeprom_pkg::CS_STOP) && cmd_done;
            if (start_req)
                is_read <= !WR;
            if ((state == eeprom_pkg::CS_DATA_RD) && cmd_done)
                rd_data <= rx_byte;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
        begin
            cmd       <= cmd_next;
            tx_byte   <= tx_next;
            last_read <= last_next;
        end
    end

endmodule

//--- eeprom/i2c_shifter.sv
module i2c_shifter (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_valid,
    input  eeprom_pkg::i2c_cmd_t      cmd,
    input  eeprom_pkg::eeprom_byte_t  tx_byte,
    input  logic                      last_read,
    output logic                      cmd_done,
    output eeprom_pkg::eeprom_byte_t  rx_byte,
    output logic                      scl,
    output logic                      sda_low,
    input  logic                      sda_in
);

    eeprom_pkg::shift_state_t state;
    eeprom_pkg::quarter_cnt_t qcnt;
    eeprom_pkg::phase_t       phase;
    eeprom_pkg::bit_cnt_t     bit_cnt;
    eeprom_pkg::eeprom_byte_t tx_sh;
    eeprom_pkg::eeprom_byte_t rx_sh;
    logic                     nack;
    logic                     scl_hold;       // bus levels kept between commands
    logic                     sda_hold_low;
    logic                     accept;
    logic                     q_end;
    logic                     bit_end;
    logic                     last_bit;
    logic                     sample;

    assign accept   = (state == eeprom_pkg::SH_IDLE) && cmd_valid;
    assign q_end    = (qcnt == eeprom_pkg::QUARTER_LAST);
    assign bit_end  = (state != eeprom_pkg::SH_IDLE) && q_end && (phase == 2'd3);
    assign last_bit = (state == eeprom_pkg::SH_START) || (state == eeprom_pkg::SH_STOP) ||
                      (bit_cnt == eeprom_pkg::ACK_SLOT);
    assign cmd_done = bit_end && last_bit;

    // mid-high, end of the first high quarter
    assign sample = (state == eeprom_pkg::SH_READ) && q_end && (phase == 2'd1) &&
                    (bit_cnt != eeprom_pkg::ACK_SLOT);

    assign rx_byte = rx_sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= eeprom_pkg::SH_IDLE;
            qcnt         <= '0;
            phase        <= '0;
            bit_cnt      <= '0;
            scl_hold     <= 1'b1;
            sda_hold_low <= 1'b0;
        end
        else if (accept)
        begin
            case (cmd)
                eeprom_pkg::CMD_START: state <= eeprom_pkg::SH_START;
                eeprom_pkg::CMD_STOP:  state <= eeprom_pkg::SH_STOP;
                eeprom_pkg::CMD_WRITE: state <= eeprom_pkg::SH_WRITE;
                default:               state <= eeprom_pkg::SH_READ;
            endcase
            qcnt    <= '0;
            phase   <= '0;
            bit_cnt <= '0;
        end
        else if (state != eeprom_pkg::SH_IDLE)
        begin
            if (q_end)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        state        <= eeprom_pkg::SH_IDLE;
                        scl_hold     <= (state == eeprom_pkg::SH_STOP);
                        sda_hold_low <= (state == eeprom_pkg::SH_START);
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
            else
            begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            tx_sh <= tx_byte;
            nack  <= last_read;
        end
        else
        begin
            if ((state == eeprom_pkg::SH_WRITE) && bit_end)
                tx_sh <= {tx_sh[6:0], 1'b0};   // msb first
            if (sample)
                rx_sh <= {rx_sh[6:0], sda_in};
        end
    end

    // scl high in quarters 1 and 2 of a data bit
    always_comb
    begin
        scl     = scl_hold;
        sda_low = sda_hold_low;
        case (state)
            eeprom_pkg::SH_START:
            begin
                scl     = (phase == 2'd0) ? scl_hold : (phase != 2'd3);
                sda_low = phase[1];   // sda falls while scl high
            end
            eeprom_pkg::SH_STOP:
            begin
                scl     = (phase != 2'd0);
                sda_low = !phase[1];
            end
            eeprom_pkg::SH_WRITE:
            begin
                scl     = phase[0] ^ phase[1];
                sda_low = (bit_cnt != eeprom_pkg::ACK_SLOT) && !tx_sh[7];
            end
            eeprom_pkg::SH_READ:
            begin
                scl     = phase[0] ^ phase[1];
                sda_low = (bit_cnt == eeprom_pkg::ACK_SLOT) && !nack;   // master ack
            end
            default:
            begin
                scl     = scl_hold;
                sda_low = sda_hold_low;
            end
        endcase
    end

endmodule

//--- common/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int BYTE_W = 8;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;   // [10:8] block, [7:0] word
    typedef logic [BYTE_W-1:0] eeprom_byte_t;

    // device type code, upper nibble of every control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

    // clk cycles per quarter of an scl period
    localparam int QUARTER_CYCLES = 1;
    localparam int QCNT_W = 4;

    typedef logic [QCNT_W-1:0] quarter_cnt_t;
    typedef logic [1:0] phase_t;     // quarter index within one scl period
    typedef logic [3:0] bit_cnt_t;   // 0..7 data, 8 ack slot

    localparam quarter_cnt_t QUARTER_LAST = quarter_cnt_t'(QUARTER_CYCLES - 1);
    localparam bit_cnt_t ACK_SLOT = 4'd8;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_t;

    typedef enum logic [3:0] {
        CS_IDLE,
        CS_WR_START,
        CS_CTRL_WR,
        CS_ADDR_WR,
        CS_DATA_WR,
        CS_RD_START,
        CS_CTRL_RD,
        CS_DATA_RD,
        CS_STOP,
        CS_ACK
    } ctrl_state_t;

    typedef enum logic [2:0] {
        SH_IDLE,
        SH_START,
        SH_STOP,
        SH_WRITE,
        SH_READ
    } shift_state_t;

endpackage
